// ==== scd_params.svh ====
`ifndef SCD_PARAMS_SVH
`define SCD_PARAMS_SVH

// SCAD, FE and SC width, bit 9 is the sign
`define SCD_WIDTH 10
`define AR_WIDTH 36
`define MAGIC_WIDTH 9

// AR is numbered from the left, AR bit 0 sits at vector index 35
`define AR_IDX(n) (`AR_WIDTH - 1 - (n))

// AR bits that carry the flags on a flag load
`define AR_OV_BIT 0
`define AR_CRY0_BIT 1
`define AR_CRY1_BIT 2
`define AR_FOV_BIT 3
`define AR_FPD_BIT 4
`define AR_FXU_BIT 11
`define AR_DIV_CHK_BIT 12
`define AR_SC_SIGN_BIT 18

`endif

// ==== scdPkg.sv ====
`default_nettype none

package scdPkg;

  // SCAD functions as coded in the microcode SCAD field
  typedef enum logic [2:0] {
    FuncA              = 3'd0,
    FuncAminusBminus1  = 3'd1,
    FuncAplusB         = 3'd2,
    FuncAminus1        = 3'd3,
    FuncAplus1         = 3'd4,
    FuncAminusB        = 3'd5,
    FuncOr             = 3'd6,
    FuncAnd            = 3'd7
  } scadFunc_t;

  // Codes 4 to 7 disable the A mux and give zero
  typedef enum logic [2:0] {
    ScadaFe    = 3'd0,
    ScadaArExp = 3'd1,
    ScadaArPos = 3'd2,
    ScadaMagic = 3'd3,
    ScadaOff   = 3'd4
  } scadaSel_t;

  typedef enum logic [1:0] {
    ScbSc      = 2'd0,
    ScbArField = 2'd1,
    ScbAlt     = 2'd2,
    ScbMagic   = 2'd3
  } scbSel_t;

  // SC source select
  typedef enum logic [1:0] {
    ScHold = 2'd0,
    ScFe   = 2'd1,
    ScScad = 2'd2,
    ScAr   = 2'd3
  } scSel_t;

endpackage

`default_nettype wire

// ==== scadOperandSelect.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scd_params.svh"

module scadOperandSelect (
  input  wire logic [`AR_WIDTH-1:0]    ar,
  input  wire logic [`MAGIC_WIDTH-1:0] magic,
  input  wire logic [`SCD_WIDTH-1:0]   fe,
  input  wire logic [`SCD_WIDTH-1:0]   sc,
  input  scdPkg::scadaSel_t            scadaSel,
  input  scdPkg::scbSel_t              scadbSel,
  output logic [`SCD_WIDTH-1:0]        scadA,
  output logic [`SCD_WIDTH-1:0]        scadB
);

  import scdPkg::*;

  logic [7:0] arExp;
  logic [5:0] arPos;
  logic [5:0] arField;
  logic [8:0] arAlt;

  // Exponent field, ones-complemented when the word is negative
  assign arExp = ar[`AR_IDX(1) -: 8] ^ {8{ar[`AR_IDX(0)]}};

  // AR bits 0-5, the byte position
  assign arPos = ar[`AR_IDX(0) -: 6];

  // AR bits 6-11, the byte size
  assign arField = ar[`AR_IDX(6) -: 6];

  assign arAlt = ar[`AR_IDX(0) -: 9];

  always_comb begin
    case (scadaSel)
      ScadaFe:    scadA = fe;
      ScadaArExp: scadA = {{(`SCD_WIDTH - 8){1'b0}}, arExp};
      ScadaArPos: scadA = {{(`SCD_WIDTH - 6){1'b0}}, arPos};
      ScadaMagic: scadA = {{(`SCD_WIDTH - `MAGIC_WIDTH){1'b0}}, magic};
      default:    scadA = '0;
    endcase
  end

  always_comb begin
    case (scadbSel)
      ScbSc:      scadB = sc;
      ScbArField: scadB = {{(`SCD_WIDTH - 6){1'b0}}, arField};
      ScbAlt:     scadB = {{(`SCD_WIDTH - 9){1'b0}}, arAlt};
      default:    scadB = {{(`SCD_WIDTH - `MAGIC_WIDTH){1'b0}}, magic};
    endcase
  end

endmodule

`default_nettype wire

// ==== scadAdder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scd_params.svh"

module scadAdder (
  input  scdPkg::scadFunc_t          func,
  input  wire logic [`SCD_WIDTH-1:0] scadA,
  input  wire logic [`SCD_WIDTH-1:0] scadB,
  output logic [`SCD_WIDTH-1:0]      scad,
  output logic                       scadZero
);

  import scdPkg::*;

  logic [`SCD_WIDTH-1:0] bTerm;
  logic                  carryIn;
  logic [`SCD_WIDTH-1:0] sum;

  // B term and carry in for each arithmetic function, like the 10181 select lines
  always_comb begin
    bTerm   = '0;
    carryIn = 1'b0;
    case (func)
      FuncAminusBminus1: bTerm = ~scadB;
      FuncAplusB:        bTerm = scadB;
      FuncAminus1:       bTerm = '1;
      FuncAplus1:        carryIn = 1'b1;
      FuncAminusB: begin
        bTerm   = ~scadB;
        carryIn = 1'b1;
      end
      default: begin
        bTerm   = '0;
        carryIn = 1'b0;
      end
    endcase
  end

  // Carry out of the sign is dropped, results wrap modulo 1024
  assign sum = scadA + bTerm + {{(`SCD_WIDTH - 1){1'b0}}, carryIn};

  always_comb begin
    case (func)
      FuncOr:  scad = scadA | scadB;
      FuncAnd: scad = scadA & scadB;
      default: scad = sum;
    endcase
  end

  assign scadZero = (scad == '0);

endmodule

`default_nettype wire

// ==== feScRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scd_params.svh"

module feScRegisters (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic [`SCD_WIDTH-1:0] scad,
  input  wire logic [`AR_WIDTH-1:0]  ar,
  input  wire logic                  feLoad,
  input  wire logic                  feShift,
  input  scdPkg::scSel_t             scSel,
  output logic [`SCD_WIDTH-1:0]      fe,
  output logic [`SCD_WIDTH-1:0]      sc,
  output logic                       scSign,
  output logic                       scGe36
);

  import scdPkg::*;

  logic [`SCD_WIDTH-1:0] scFromAr;

  // AR 18 is the sign of the right half, extended over the top two bits
  assign scFromAr = {{2{ar[`AR_IDX(`AR_SC_SIGN_BIT)]}}, ar[`AR_IDX(28):`AR_IDX(35)]};

  // Floating exponent register, load wins over shift
  always_ff @(posedge clk) begin
    if (reset) begin
      fe <= '0;
    end else if (feLoad) begin
      fe <= scad;
    end else if (feShift) begin
      fe <= {fe[`SCD_WIDTH-1], fe[`SCD_WIDTH-1:1]};
    end
  end

  // Shift counter
  always_ff @(posedge clk) begin
    if (reset) begin
      sc <= '0;
    end else begin
      case (scSel)
        ScFe:    sc <= fe;
        ScScad:  sc <= scad;
        ScAr:    sc <= scFromAr;
        default: sc <= sc;
      endcase
    end
  end

  assign scSign = sc[`SCD_WIDTH-1];

  // Any of the top four bits set means a count of 64 or more, or negative
  assign scGe36 = |sc[`SCD_WIDTH-1 -: 4];

  property pResetClears;
    @(posedge clk) reset |=> (fe == '0 && sc == '0);
  endproperty
  assert property (pResetClears)
    else $error("FE or SC not cleared by reset");

  property pShiftKeepsSign;
    @(posedge clk) (!reset && feShift && !feLoad) |=> $stable(fe[`SCD_WIDTH-1]);
  endproperty
  assert property (pShiftKeepsSign)
    else $error("FE sign changed on a shift");

endmodule

`default_nettype wire

// ==== arithFlags.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scd_params.svh"

module arithFlags (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic [`AR_WIDTH-1:0]  ar,
  input  wire logic [`SCD_WIDTH-1:0] scad,
  input  wire logic                  adOv,
  input  wire logic                  adCry0,
  input  wire logic                  adCry1,
  input  wire logic                  setAdFlags,
  input  wire logic                  expTest,
  input  wire logic                  setDivChk,
  input  wire logic                  setFpd,
  input  wire logic                  clearFpd,
  input  wire logic                  loadFlags,
  output logic                       ov,
  output logic                       cry0,
  output logic                       cry1,
  output logic                       fov,
  output logic                       fxu,
  output logic                       divChk,
  output logic                       fpd
);

  logic expOverflow;
  logic expUnderflow;

  // Bit below the sign set means the exponent left its range
  assign expOverflow  = expTest & scad[`SCD_WIDTH-2];
  assign expUnderflow = expTest & scad[`SCD_WIDTH-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      ov     <= 1'b0;
      cry0   <= 1'b0;
      cry1   <= 1'b0;
      fov    <= 1'b0;
      fxu    <= 1'b0;
      divChk <= 1'b0;
      fpd    <= 1'b0;
    end else if (loadFlags) begin
      ov     <= ar[`AR_IDX(`AR_OV_BIT)];
      cry0   <= ar[`AR_IDX(`AR_CRY0_BIT)];
      cry1   <= ar[`AR_IDX(`AR_CRY1_BIT)];
      fov    <= ar[`AR_IDX(`AR_FOV_BIT)];
      fxu    <= ar[`AR_IDX(`AR_FXU_BIT)];
      divChk <= ar[`AR_IDX(`AR_DIV_CHK_BIT)];
      fpd    <= ar[`AR_IDX(`AR_FPD_BIT)];
    end else begin
      // Sticky until the next flag load
      ov     <= ov | (setAdFlags & adOv) | expOverflow;
      cry0   <= cry0 | (setAdFlags & adCry0);
      cry1   <= cry1 | (setAdFlags & adCry1);
      fov    <= fov | expOverflow;
      fxu    <= fxu | expUnderflow;
      divChk <= divChk | setDivChk;
      // Set wins when both come in one cycle
      if (setFpd) begin
        fpd <= 1'b1;
      end else if (clearFpd) begin
        fpd <= 1'b0;
      end
    end
  end

  property pOvSticky;
    @(posedge clk) (ov && !reset && !loadFlags) |=> ov;
  endproperty
  assert property (pOvSticky)
    else $error("OV cleared without reset or flag load");

endmodule

`default_nettype wire

// ==== scdDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scd_params.svh"

module scdDatapath (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic [`AR_WIDTH-1:0]    ar,
  input  wire logic [`MAGIC_WIDTH-1:0] magic,
  input  scdPkg::scadFunc_t            scadFunc,
  input  scdPkg::scadaSel_t            scadaSel,
  input  scdPkg::scbSel_t              scadbSel,
  input  wire logic                    feLoad,
  input  wire logic                    feShift,
  input  scdPkg::scSel_t               scSel,
  input  wire logic                    adOv,
  input  wire logic                    adCry0,
  input  wire logic                    adCry1,
  input  wire logic                    setAdFlags,
  input  wire logic                    expTest,
  input  wire logic                    setDivChk,
  input  wire logic                    setFpd,
  input  wire logic                    clearFpd,
  input  wire logic                    loadFlags,
  output logic [`SCD_WIDTH-1:0]        scad,
  output logic                         scadZero,
  output logic [`SCD_WIDTH-1:0]        fe,
  output logic [`SCD_WIDTH-1:0]        sc,
  output logic                         scSign,
  output logic                         scGe36,
  output logic                         ov,
  output logic                         cry0,
  output logic                         cry1,
  output logic                         fov,
  output logic                         fxu,
  output logic                         divChk,
  output logic                         fpd
);

  logic [`SCD_WIDTH-1:0] scadA;
  logic [`SCD_WIDTH-1:0] scadB;

  scadOperandSelect uOperandSelect (
    .ar       (ar),
    .magic    (magic),
    .fe       (fe),
    .sc       (sc),
    .scadaSel (scadaSel),
    .scadbSel (scadbSel),
    .scadA    (scadA),
    .scadB    (scadB)
  );

  scadAdder uScadAdder (
    .func     (scadFunc),
    .scadA    (scadA),
    .scadB    (scadB),
    .scad     (scad),
    .scadZero (scadZero)
  );

  feScRegisters uFeScRegisters (
    .clk     (clk),
    .reset   (reset),
    .scad    (scad),
    .ar      (ar),
    .feLoad  (feLoad),
    .feShift (feShift),
    .scSel   (scSel),
    .fe      (fe),
    .sc      (sc),
    .scSign  (scSign),
    .scGe36  (scGe36)
  );

  arithFlags uArithFlags (
    .clk        (clk),
    .reset      (reset),
    .ar         (ar),
    .scad       (scad),
    .adOv       (adOv),
    .adCry0     (adCry0),
    .adCry1     (adCry1),
    .setAdFlags (setAdFlags),
    .expTest    (expTest),
    .setDivChk  (setDivChk),
    .setFpd     (setFpd),
    .clearFpd   (clearFpd),
    .loadFlags  (loadFlags),
    .ov         (ov),
    .cry0       (cry0),
    .cry1       (cry1),
    .fov        (fov),
    .fxu        (fxu),
    .divChk     (divChk),
    .fpd        (fpd)
  );

endmodule

`default_nettype wire

// ==== tbScdDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scd_params.svh"

module tbScdDatapath;

  import scdPkg::*;

  typedef logic [`SCD_WIDTH-1:0] scdWord_t;
  typedef logic [`AR_WIDTH-1:0] arWord_t;

  localparam int ClkPeriod = 20;
  localparam int DriveDelay = 2;
  localparam int ResetCycles = 8;
  localparam int ScadTrials = 3;
  // 8 functions x 8 A codes x 4 B codes per trial, plus one preload cycle
  localparam int ScadCycles = ScadTrials * (8 * 8 * 4 + 1);
  localparam int OtherCycles = 80;
  localparam int TimeoutNs = (ResetCycles + ScadCycles + OtherCycles + 100) * ClkPeriod;

  logic clk;
  logic reset;
  arWord_t ar;
  logic [`MAGIC_WIDTH-1:0] magic;
  scadFunc_t scadFunc;
  scadaSel_t scadaSel;
  scbSel_t scadbSel;
  scSel_t scSel;
  logic feLoad, feShift, adOv, adCry0, adCry1, setAdFlags;
  logic expTest, setDivChk, setFpd, clearFpd, loadFlags;
  scdWord_t scad, fe, sc;
  logic scadZero, scSign, scGe36;
  logic ov, cry0, cry1, fov, fxu, divChk, fpd;

  integer seed;
  scdWord_t expFe;
  scdWord_t expSc;

  scdDatapath u_scdDatapath (
    .clk(clk), .reset(reset), .ar(ar), .magic(magic), .scadFunc(scadFunc),
    .scadaSel(scadaSel), .scadbSel(scadbSel), .feLoad(feLoad), .feShift(feShift),
    .scSel(scSel), .adOv(adOv), .adCry0(adCry0), .adCry1(adCry1),
    .setAdFlags(setAdFlags), .expTest(expTest), .setDivChk(setDivChk),
    .setFpd(setFpd), .clearFpd(clearFpd), .loadFlags(loadFlags),
    .scad(scad), .scadZero(scadZero), .fe(fe), .sc(sc), .scSign(scSign),
    .scGe36(scGe36), .ov(ov), .cry0(cry0), .cry1(cry1), .fov(fov), .fxu(fxu),
    .divChk(divChk), .fpd(fpd)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  initial begin
    #(TimeoutNs);
    $display("timeout: the tests did not finish within %0d ns", TimeoutNs);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  // AR numbering runs from the left, bit 0 is the MSB
  function automatic logic arBit(input arWord_t word, input int n);
    return word[`AR_WIDTH-1-n];
  endfunction

  function automatic arWord_t arBits(input arWord_t word, input int first, input int last);
    arWord_t field;
    int i;
    field = '0;
    for (i = first; i <= last; i++) begin
      field = {field[`AR_WIDTH-2:0], arBit(word, i)};
    end
    return field;
  endfunction

  function automatic scdWord_t modelA(input int code, input arWord_t word,
                                      input logic [`MAGIC_WIDTH-1:0] m, input scdWord_t feVal);
    arWord_t exponent;
    exponent = arBits(word, 1, 8);
    if (arBit(word, 0)) begin
      exponent = exponent ^ arWord_t'(8'hff);
    end
    case (code)
      0: return feVal;
      1: return scdWord_t'(exponent);
      2: return scdWord_t'(arBits(word, 0, 5));
      3: return scdWord_t'(m);
      default: return '0;
    endcase
  endfunction

  function automatic scdWord_t modelB(input int code, input arWord_t word,
                                      input logic [`MAGIC_WIDTH-1:0] m, input scdWord_t scVal);
    case (code)
      0: return scVal;
      1: return scdWord_t'(arBits(word, 6, 11));
      2: return scdWord_t'(arBits(word, 0, 8));
      default: return scdWord_t'(m);
    endcase
  endfunction

  function automatic scdWord_t modelScad(input int func, input scdWord_t a, input scdWord_t b);
    int av;
    int bv;
    int r;
    av = int'(a);
    bv = int'(b);
    case (func)
      0: r = av;
      1: r = av - bv - 1;
      2: r = av + bv;
      3: r = av - 1;
      4: r = av + 1;
      5: r = av - bv;
      6: r = av | bv;
      default: r = av & bv;
    endcase
    return scdWord_t'(r);
  endfunction

  // AR 18 fills the top two bits, AR 28-35 the rest
  function automatic scdWord_t scFromAr(input arWord_t word);
    logic [7:0] low;
    low = 8'(arBits(word, 28, 35));
    return {arBit(word, 18), arBit(word, 18), low};
  endfunction

  task automatic driveOperands(input int func, input int aSel, input int bSel);
    scadFunc = scadFunc_t'(3'(func));
    scadaSel = scadaSel_t'(3'(aSel));
    scadbSel = scbSel_t'(2'(bSel));
  endtask

  task automatic idleControls();
    feLoad = 1'b0;
    feShift = 1'b0;
    scSel = ScHold;
    {adOv, adCry0, adCry1, setAdFlags} = 4'b0;
    {expTest, setDivChk, setFpd, clearFpd, loadFlags} = 5'b0;
  endtask

  task automatic clockStep();
    @(posedge clk);
    #DriveDelay;
    idleControls();
  endtask

  task automatic checkSc();
    checkValue("sc", 32'(sc), 32'(expSc));
    checkValue("scSign", 32'(scSign), 32'(expSc >= scdWord_t'(512)));
    checkValue("scGe36", 32'(scGe36), 32'(expSc >= scdWord_t'(64)));
  endtask

  // Order is ov, cry0, cry1, fov, fxu, divChk, fpd
  task automatic checkFlags(input logic [6:0] expected);
    checkValue("ov", 32'(ov), 32'(expected[6]));
    checkValue("cry0", 32'(cry0), 32'(expected[5]));
    checkValue("cry1", 32'(cry1), 32'(expected[4]));
    checkValue("fov", 32'(fov), 32'(expected[3]));
    checkValue("fxu", 32'(fxu), 32'(expected[2]));
    checkValue("divChk", 32'(divChk), 32'(expected[1]));
    checkValue("fpd", 32'(fpd), 32'(expected[0]));
  endtask

  task automatic testScadFunctions();
    int trial;
    int func;
    int aSel;
    int bSel;
    scdWord_t expected;
    for (trial = 0; trial < ScadTrials; trial++) begin
      // Random FE from magic + AR 0-8, random SC from AR
      ar = arWord_t'({$random(seed), $random(seed)});
      magic = 9'($random(seed));
      driveOperands(2, 3, 2);
      feLoad = 1'b1;
      scSel = ScAr;
      expFe = modelScad(2, modelA(3, ar, magic, expFe), modelB(2, ar, magic, expSc));
      expSc = scFromAr(ar);
      clockStep();
      checkValue("fe", 32'(fe), 32'(expFe));
      checkSc();
      ar = arWord_t'({$random(seed), $random(seed)});
      magic = 9'($random(seed));
      for (func = 0; func < 8; func++) begin
        for (aSel = 0; aSel < 8; aSel++) begin
          for (bSel = 0; bSel < 4; bSel++) begin
            driveOperands(func, aSel, bSel);
            expected = modelScad(func, modelA(aSel, ar, magic, expFe),
                                 modelB(bSel, ar, magic, expSc));
            #5;
            checkValue("scad", 32'(scad), 32'(expected));
            checkValue("scadZero", 32'(scadZero), 32'(expected == '0));
            clockStep();
          end
        end
      end
    end
  endtask

  task automatic testFeRegister();
    // Magic with bit 8 set doubled gives a negative FE
    magic = {1'b1, 8'($random(seed))};
    driveOperands(2, 3, 3);
    feLoad = 1'b1;
    expFe = modelScad(2, scdWord_t'(magic), scdWord_t'(magic));
    clockStep();
    checkValue("fe", 32'(fe), 32'(expFe));
    repeat (4) begin
      feShift = 1'b1;
      expFe = scdWord_t'($signed(expFe) >>> 1);
      clockStep();
      checkValue("fe", 32'(fe), 32'(expFe));
    end
    magic = {1'b0, 8'($random(seed))};
    driveOperands(0, 3, 0);
    feLoad = 1'b1;
    expFe = scdWord_t'(magic);
    clockStep();
    repeat (3) begin
      feShift = 1'b1;
      expFe = scdWord_t'($signed(expFe) >>> 1);
      clockStep();
      checkValue("fe", 32'(fe), 32'(expFe));
    end
    // Load and shift together
    magic = 9'($random(seed));
    feLoad = 1'b1;
    feShift = 1'b1;
    expFe = scdWord_t'(magic);
    clockStep();
    checkValue("fe", 32'(fe), 32'(expFe));
  endtask

  task automatic testScSources();
    int i;
    magic = 9'($random(seed));
    driveOperands(0, 3, 0);
    scSel = ScScad;
    expSc = scdWord_t'(magic);
    clockStep();
    checkSc();
    repeat (2) begin
      magic = 9'($random(seed));
      clockStep();
      checkSc();
    end
    scSel = ScFe;
    expSc = expFe;
    clockStep();
    checkSc();
    for (i = 0; i < 4; i++) begin
      ar = arWord_t'({$random(seed), $random(seed)});
      ar[`AR_WIDTH-1-18] = i[0];
      scSel = ScAr;
      expSc = scFromAr(ar);
      clockStep();
      checkSc();
    end
  endtask

  task automatic testFlags();
    logic [6:0] expFlags;
    scdWord_t s;
    repeat (3) begin
      ar = arWord_t'({$random(seed), $random(seed)});
      loadFlags = 1'b1;
      expFlags = {arBit(ar, 0), arBit(ar, 1), arBit(ar, 2), arBit(ar, 3),
                  arBit(ar, 11), arBit(ar, 12), arBit(ar, 4)};
      clockStep();
      checkFlags(expFlags);
    end
    ar = '0;
    loadFlags = 1'b1;
    clockStep();
    checkFlags(7'b0);
    {setAdFlags, adOv} = 2'b11;
    clockStep();
    checkFlags(7'b1000000);
    {setAdFlags, adCry0} = 2'b11;
    clockStep();
    checkFlags(7'b1100000);
    {setAdFlags, adCry1} = 2'b11;
    clockStep();
    checkFlags(7'b1110000);
    loadFlags = 1'b1;
    clockStep();
    // Exponent tests on SCAD 0x100, then 0x200
    expFlags = 7'b0;
    magic = 9'h100;
    driveOperands(0, 3, 0);
    repeat (2) begin
      s = modelScad(int'(scadFunc), scdWord_t'(magic), scdWord_t'(magic));
      expTest = 1'b1;
      expFlags = expFlags | {s[8], 2'b0, s[8], s[9], 2'b0};
      clockStep();
      checkFlags(expFlags);
      driveOperands(2, 3, 3);
    end
    setDivChk = 1'b1;
    clockStep();
    checkFlags(expFlags | 7'b0000010);
    setFpd = 1'b1;
    clockStep();
    checkFlags(expFlags | 7'b0000011);
    clearFpd = 1'b1;
    clockStep();
    checkFlags(expFlags | 7'b0000010);
    // Flag load of zero beats every sticky set in the same cycle
    magic = 9'h180;
    {setAdFlags, adOv, adCry0, adCry1, expTest, setDivChk, setFpd} = 7'h7f;
    loadFlags = 1'b1;
    clockStep();
    checkFlags(7'b0);
  endtask

  initial begin
    seed = 32'he7a3_4198;
    reset = 1'b1;
    ar = '0;
    magic = '0;
    driveOperands(0, 0, 0);
    idleControls();
    expFe = '0;
    expSc = '0;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    reset = 1'b0;
    checkValue("fe", 32'(fe), 32'(expFe));
    checkSc();
    checkFlags(7'b0);
    testScadFunctions();
    testFeRegister();
    testScSources();
    testFlags();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== scdDatapath.f ====
+incdir+.
scdPkg.sv
scadOperandSelect.sv
scadAdder.sv
feScRegisters.sv
arithFlags.sv
scdDatapath.sv
tbScdDatapath.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tbScdDatapath
DUT_TOP    := scdDatapath
FILELIST   := scdDatapath.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
